// File: verilog/sdmacPkg.sv
/*
 * SCSI DMA controller shared definitions
 * FIFO word layout, register offsets and control/status bit positions
 */
package sdmacPkg;

    // One FIFO entry, seen as a longword or as four byte lanes
    // Lane 3 is the most significant and the first byte on the SCSI side
    typedef union packed {
        logic [31:0]     lword;
        logic [3:0][7:0] bytes;
    } fifoWordT;

    // Word offsets on the CPU register port
    localparam logic [1:0] REG_ADDR = 2'd0;  // Start address
    localparam logic [1:0] REG_LEN  = 2'd1;  // Length in longwords
    localparam logic [1:0] REG_CNTR = 2'd2;  // Control
    localparam logic [1:0] REG_ISTR = 2'd3;  // Status

    // Control register bits
    localparam int CNTR_DIR   = 0;  // 1 = memory to SCSI
    localparam int CNTR_EN    = 1;  // Write 1 to start
    localparam int CNTR_INTEN = 2;

    // Status register bits
    localparam int ISTR_DONE = 0;  // Write 1 to clear
    localparam int ISTR_INT  = 1;
    localparam int ISTR_FE   = 2;
    localparam int ISTR_FF   = 3;

endpackage

// File: verilog/sdmacRegs.sv
/*
 * SDMAC register block
 * CPU valid/ready slave for address, length, control and status, plus interrupt
 */
`timescale 1ns/100ps

module sdmacRegs
    import sdmacPkg::*;
(
    input  logic        QnCPUCLK,
    input  logic        rstN_i,
    input  logic        regValid_i,
    input  logic        regWrite_i,
    input  logic [1:0]  regAddr_i,
    input  logic [31:0] regWdata_i,
    output logic        regReady_o,
    output logic [31:0] regRdata_o,
    input  logic        fifoEmpty_i,
    input  logic        fifoFull_i,
    input  logic        xferDone_i,
    output logic        dir_o,
    output logic        start_o,
    output logic [31:0] startAddr_o,
    output logic [15:0] lenWords_o,
    output logic        intO
);

    logic [31:0] addrReg;
    logic [15:0] lenReg;
    logic        dirBit;
    logic        enBit;
    logic        intEnBit;
    logic        doneFlag;
    logic        intPending;
    logic        access;      // First cycle of a CPU request
    logic        wrStrobe;
    logic [31:0] cntrWord;
    logic [31:0] statusWord;
    logic [31:0] rdMux;

    assign access   = regValid_i && !regReady_o;
    assign wrStrobe = access && regWrite_i;

    assign intPending = doneFlag && intEnBit;
    assign intO       = intPending;

    assign dir_o       = dirBit;
    assign startAddr_o = addrReg;
    assign lenWords_o  = lenReg;

    always_comb begin
        cntrWord             = '0;
        cntrWord[CNTR_DIR]   = dirBit;
        cntrWord[CNTR_EN]    = enBit;
        cntrWord[CNTR_INTEN] = intEnBit;
    end

    always_comb begin
        statusWord            = '0;
        statusWord[ISTR_DONE] = doneFlag;
        statusWord[ISTR_INT]  = intPending;
        statusWord[ISTR_FE]   = fifoEmpty_i;  // Live FIFO flags
        statusWord[ISTR_FF]   = fifoFull_i;
    end

    always_comb begin
        case (regAddr_i)
            REG_ADDR: rdMux = addrReg;
            REG_LEN:  rdMux = {16'h0000, lenReg};
            REG_CNTR: rdMux = cntrWord;
            default:  rdMux = statusWord;
        endcase
    end

    always_ff @(posedge QnCPUCLK) begin
        if (!rstN_i) begin
            regReady_o <= 1'b0;
            regRdata_o <= '0;
            start_o    <= 1'b0;
            addrReg    <= '0;
            lenReg     <= '0;
            dirBit     <= 1'b0;
            enBit      <= 1'b0;
            intEnBit   <= 1'b0;
            doneFlag   <= 1'b0;
        end else begin
            regReady_o <= access;  // One cycle, answers the request
            start_o    <= wrStrobe && (regAddr_i == REG_CNTR) && regWdata_i[CNTR_EN];
            if (access) begin
                regRdata_o <= rdMux;
            end
            if (wrStrobe) begin
                case (regAddr_i)
                    REG_ADDR: addrReg <= regWdata_i;
                    REG_LEN:  lenReg  <= regWdata_i[15:0];
                    REG_CNTR: begin
                        dirBit   <= regWdata_i[CNTR_DIR];
                        enBit    <= regWdata_i[CNTR_EN];
                        intEnBit <= regWdata_i[CNTR_INTEN];
                    end
                    default: ;  // Status is cleared below
                endcase
            end
            // Done wins over a clear in the same cycle
            if (xferDone_i) begin
                doneFlag <= 1'b1;
            end else if (wrStrobe && (regAddr_i == REG_ISTR) && regWdata_i[ISTR_DONE]) begin
                doneFlag <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/sdmacFifo.sv
/*
 * SDMAC longword FIFO
 * Packs SCSI bytes into longwords and unpacks longwords into bytes, MSB lane first
 */
`timescale 1ns/100ps

module sdmacFifo
    import sdmacPkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       QnCPUCLK,
    input  logic       rstN_i,
    input  logic       clear_i,
    input  logic       bytePush_i,
    input  logic [7:0] byteIn_i,
    input  logic       bytePop_i,
    output logic [7:0] byteOut_o,
    input  logic       wordPush_i,
    input  fifoWordT   wordIn_i,
    input  logic       wordPop_i,
    output fifoWordT   wordOut_o,
    output logic       byteRoom_o,
    output logic       byteAvail_o,
    output logic       fifoEmpty_o,
    output logic       fifoFull_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    fifoWordT         ring [FIFO_DEPTH];
    fifoWordT         packWord;   // Partly filled write-side word
    fifoWordT         packNext;
    fifoWordT         headWord;
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   wordCount;
    logic [1:0]       bytePtrWr;  // Bytes already packed
    logic [1:0]       bytePtrRd;  // Bytes already unpacked
    logic             byteCommit;
    logic             lastBytePop;
    logic             doPush;
    logic             doPop;

    // Byte 0 of the transfer goes to lane 3
    always_comb begin
        packNext                          = packWord;
        packNext.bytes[2'd3 - bytePtrWr] = byteIn_i;
    end

    assign byteCommit  = bytePush_i && (bytePtrWr == 2'd3);
    assign lastBytePop = bytePop_i && (bytePtrRd == 2'd3);
    assign doPush      = byteCommit || wordPush_i;
    assign doPop       = lastBytePop || wordPop_i;

    assign headWord  = ring[rdPtr];
    assign wordOut_o = headWord;
    assign byteOut_o = headWord.bytes[2'd3 - bytePtrRd];

    assign fifoEmpty_o = (wordCount == '0);
    assign fifoFull_o  = (wordCount == (PTR_W + 1)'(FIFO_DEPTH));
    assign byteRoom_o  = !fifoFull_o;   // Commit of a fourth byte always finds a slot
    assign byteAvail_o = !fifoEmpty_o;

    // Storage
    always_ff @(posedge QnCPUCLK) begin
        if (byteCommit) begin
            ring[wrPtr] <= packNext;
        end else if (wordPush_i) begin
            ring[wrPtr] <= wordIn_i;
        end
        if (bytePush_i) begin
            packWord <= packNext;
        end
    end

    always_ff @(posedge QnCPUCLK) begin
        if (!rstN_i || clear_i) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            wordCount <= '0;
            bytePtrWr <= 2'd0;
            bytePtrRd <= 2'd0;
        end else begin
            if (bytePush_i) begin
                bytePtrWr <= bytePtrWr + 2'd1;  // Wraps after lane 0
            end
            if (bytePop_i) begin
                bytePtrRd <= bytePtrRd + 2'd1;
            end
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   wordCount <= wordCount + 1'b1;
                2'b01:   wordCount <= wordCount - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

endmodule

// File: verilog/scsiPortSm.sv
/*
 * SCSI peripheral port FSM
 * Answers DREQ with a single-cycle DACK and moves one byte per acknowledge
 */
`timescale 1ns/100ps

module scsiPortSm (
    input  logic       QnCPUCLK,
    input  logic       rstN_i,
    input  logic       dir_i,        // 1 = memory to SCSI
    input  logic       active_i,
    input  logic       dreqI,
    output logic       dackO,
    input  logic [7:0] pdataI,
    output logic [7:0] pdataO,
    input  logic       byteRoom_i,
    input  logic       byteAvail_i,
    output logic       bytePush_o,
    output logic       bytePop_o,
    output logic [7:0] byteIn_o,
    input  logic [7:0] byteOut_i
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_ACK     = 2'd1;
    localparam logic [1:0] ST_RECOVER = 2'd2;

    logic [1:0] state;
    logic [1:0] stateNext;
    logic       fifoReady;   // FIFO can serve one byte in this direction
    logic       inAck;

    assign fifoReady = dir_i ? byteAvail_i : byteRoom_i;
    assign inAck     = (state == ST_ACK);

    always_comb begin
        stateNext = state;
        case (state)
            ST_IDLE: begin
                if (active_i && dreqI && fifoReady) begin
                    stateNext = ST_ACK;
                end
            end
            ST_ACK:     stateNext = ST_RECOVER;
            // Gives the chip a cycle to drop DREQ after DACK
            ST_RECOVER: stateNext = ST_IDLE;
            default:    stateNext = ST_IDLE;
        endcase
    end

    always_ff @(posedge QnCPUCLK) begin
        if (!rstN_i) begin
            state <= ST_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    assign dackO = inAck;

    // SCSI to memory: byte on pdataI is taken by the FIFO at the end of DACK
    assign bytePush_o = inAck && !dir_i;
    assign byteIn_o   = pdataI;

    // Memory to SCSI: head byte is driven during DACK, then popped
    assign bytePop_o = inAck && dir_i;
    assign pdataO    = bytePop_o ? byteOut_i : 8'h00;

endmodule

// File: verilog/busMasterSm.sv
/*
 * SDMAC bus master FSM
 * Bus request/grant, address and longword counters, memory valid/ready cycles
 */
`timescale 1ns/100ps

module busMasterSm
    import sdmacPkg::*;
(
    input  logic        QnCPUCLK,
    input  logic        rstN_i,
    input  logic        dir_i,         // 1 = memory to SCSI
    input  logic        start_i,
    input  logic [31:0] startAddr_i,
    input  logic [15:0] lenWords_i,
    output logic        brO,
    input  logic        bgI,
    output logic        ownO,
    output logic        memValid_o,
    input  logic        memReady_i,
    output logic        memWrite_o,
    output logic [31:0] memAddr_o,
    output logic [31:0] memWdata_o,
    input  logic [31:0] memRdata_i,
    output logic        wordPush_o,
    output fifoWordT    wordIn_o,
    output logic        wordPop_o,
    input  fifoWordT    wordOut_i,
    input  logic        fifoEmpty_i,
    input  logic        fifoFull_i,
    output logic        fifoClear_o,
    output logic        xferDone_o,
    output logic        active_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;  // Active, bus released
    localparam logic [1:0] ST_REQ  = 2'd2;  // Waiting for grant
    localparam logic [1:0] ST_BUS  = 2'd3;  // Owner of the bus

    logic [1:0]  state;
    logic [31:0] addrCnt;
    logic [15:0] wordsLeft;
    logic        canMove;    // FIFO can feed or take a longword
    logic        haveWork;
    logic        handshake;
    logic        finished;
    logic        issue;

    assign canMove   = dir_i ? !fifoFull_i : !fifoEmpty_i;
    assign haveWork  = (wordsLeft != 16'd0) && canMove;
    assign handshake = memValid_o && memReady_i;
    // Memory to SCSI also waits for the FIFO to drain to the chip
    assign finished  = (wordsLeft == 16'd0) && (!dir_i || fifoEmpty_i);
    assign issue     = (state == ST_BUS) && !memValid_o && bgI && haveWork;

    assign brO         = (state == ST_REQ) || (state == ST_BUS);
    assign ownO        = (state == ST_BUS);
    assign active_o    = (state != ST_IDLE);
    assign fifoClear_o = (state == ST_IDLE) && start_i;
    assign memAddr_o   = addrCnt;  // Only moves on a handshake

    assign wordPush_o = handshake && !memWrite_o;
    assign wordPop_o  = handshake && memWrite_o;

    always_comb begin
        wordIn_o.lword = memRdata_i;
    end

    always_ff @(posedge QnCPUCLK) begin
        if (issue) begin
            memWdata_o <= wordOut_i.lword;
        end
    end

    always_ff @(posedge QnCPUCLK) begin
        if (!rstN_i) begin
            state      <= ST_IDLE;
            addrCnt    <= '0;
            wordsLeft  <= '0;
            memValid_o <= 1'b0;
            memWrite_o <= 1'b0;
            xferDone_o <= 1'b0;
        end else begin
            xferDone_o <= (state == ST_WAIT) && finished;
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        addrCnt   <= startAddr_i;
                        wordsLeft <= lenWords_i;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (finished) begin
                        state <= ST_IDLE;
                    end else if (haveWork) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (!haveWork) begin
                        state <= ST_WAIT;
                    end else if (bgI) begin
                        state <= ST_BUS;
                    end
                end
                default: begin  // ST_BUS
                    if (memValid_o) begin
                        if (memReady_i) begin
                            memValid_o <= 1'b0;
                            addrCnt    <= addrCnt + 32'd4;
                            wordsLeft  <= wordsLeft - 16'd1;
                        end
                    end else if (issue) begin
                        memValid_o <= 1'b1;
                        memWrite_o <= !dir_i;
                    end else if (!bgI) begin
                        state <= ST_REQ;    // Grant lost between cycles
                    end else begin
                        state <= ST_WAIT;   // FIFO stalled or count done
                    end
                end
            endcase
        end
    end

endmodule

// File: verilog/sdmacTop.sv
/*
 * SCSI DMA controller top level
 * Connects register block, FIFO, SCSI port FSM and bus master FSM
 */
`timescale 1ns/100ps

module sdmacTop
    import sdmacPkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        QnCPUCLK,
    input  logic        rstN_i,
    // CPU register port
    input  logic        regValid_i,
    input  logic        regWrite_i,
    input  logic [1:0]  regAddr_i,
    input  logic [31:0] regWdata_i,
    output logic        regReady_o,
    output logic [31:0] regRdata_o,
    // Memory port
    output logic        memValid_o,
    input  logic        memReady_i,
    output logic        memWrite_o,
    output logic [31:0] memAddr_o,
    output logic [31:0] memWdata_o,
    input  logic [31:0] memRdata_i,
    // Arbitration
    output logic        brO,
    input  logic        bgI,
    output logic        ownO,
    // SCSI chip
    input  logic        dreqI,
    output logic        dackO,
    input  logic [7:0]  pdataI,
    output logic [7:0]  pdataO,
    output logic        intO
);

    logic        dir;
    logic        start;
    logic        active;
    logic        xferDone;
    logic [31:0] startAddr;
    logic [15:0] lenWords;
    logic        fifoClear;
    logic        fifoEmpty;
    logic        fifoFull;
    logic        byteRoom;
    logic        byteAvail;
    logic        bytePush;
    logic        bytePop;
    logic [7:0]  byteIn;
    logic [7:0]  byteOut;
    logic        wordPush;
    logic        wordPop;
    fifoWordT    wordIn;
    fifoWordT    wordOut;

    sdmacRegs regs0 (
        .QnCPUCLK    (QnCPUCLK),
        .rstN_i      (rstN_i),
        .regValid_i  (regValid_i),
        .regWrite_i  (regWrite_i),
        .regAddr_i   (regAddr_i),
        .regWdata_i  (regWdata_i),
        .regReady_o  (regReady_o),
        .regRdata_o  (regRdata_o),
        .fifoEmpty_i (fifoEmpty),
        .fifoFull_i  (fifoFull),
        .xferDone_i  (xferDone),
        .dir_o       (dir),
        .start_o     (start),
        .startAddr_o (startAddr),
        .lenWords_o  (lenWords),
        .intO        (intO)
    );

    sdmacFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .QnCPUCLK    (QnCPUCLK),
        .rstN_i      (rstN_i),
        .clear_i     (fifoClear),
        .bytePush_i  (bytePush),
        .byteIn_i    (byteIn),
        .bytePop_i   (bytePop),
        .byteOut_o   (byteOut),
        .wordPush_i  (wordPush),
        .wordIn_i    (wordIn),
        .wordPop_i   (wordPop),
        .wordOut_o   (wordOut),
        .byteRoom_o  (byteRoom),
        .byteAvail_o (byteAvail),
        .fifoEmpty_o (fifoEmpty),
        .fifoFull_o  (fifoFull)
    );

    scsiPortSm scsi0 (
        .QnCPUCLK    (QnCPUCLK),
        .rstN_i      (rstN_i),
        .dir_i       (dir),
        .active_i    (active),
        .dreqI       (dreqI),
        .dackO       (dackO),
        .pdataI      (pdataI),
        .pdataO      (pdataO),
        .byteRoom_i  (byteRoom),
        .byteAvail_i (byteAvail),
        .bytePush_o  (bytePush),
        .bytePop_o   (bytePop),
        .byteIn_o    (byteIn),
        .byteOut_i   (byteOut)
    );

    busMasterSm bm0 (
        .QnCPUCLK    (QnCPUCLK),
        .rstN_i      (rstN_i),
        .dir_i       (dir),
        .start_i     (start),
        .startAddr_i (startAddr),
        .lenWords_i  (lenWords),
        .brO         (brO),
        .bgI         (bgI),
        .ownO        (ownO),
        .memValid_o  (memValid_o),
        .memReady_i  (memReady_i),
        .memWrite_o  (memWrite_o),
        .memAddr_o   (memAddr_o),
        .memWdata_o  (memWdata_o),
        .memRdata_i  (memRdata_i),
        .wordPush_o  (wordPush),
        .wordIn_o    (wordIn),
        .wordPop_o   (wordPop),
        .wordOut_i   (wordOut),
        .fifoEmpty_i (fifoEmpty),
        .fifoFull_i  (fifoFull),
        .fifoClear_o (fifoClear),
        .xferDone_o  (xferDone),
        .active_o    (active)
    );

endmodule

// File: bench/clockGen.sv
/*
 * Testbench clock source
 * Free-running QnCPUCLK with a 100 ns period
 */
`timescale 1ns/100ps

module clockGen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #50 clk_o = ~clk_o;  // Half period

endmodule

// File: bench/sdmacTop_assertions.sv
/*
 * Handshake assertions bound to the SDMAC top level
 * Memory request hold, ownership, single-cycle DACK and register ready
 */
`timescale 1ns/100ps

module sdmacTop_assertions (
    input logic        QnCPUCLK,
    input logic        rstN_i,
    input logic        memValid_i,
    input logic        memReady_i,
    input logic        memWrite_i,
    input logic [31:0] memAddr_i,
    input logic [31:0] memWdata_i,
    input logic        own_i,
    input logic        dack_i,
    input logic        regReady_i
);

    // Request and its fields stay put until accepted
    property memRequestHeld;
        @(posedge QnCPUCLK) disable iff (!rstN_i)
            memValid_i && !memReady_i |=> memValid_i && $stable(memAddr_i)
                && $stable(memWrite_i) && $stable(memWdata_i);
    endproperty

    assert property (memRequestHeld)
        else $error("Memory request changed before it was accepted");

    assert property (@(posedge QnCPUCLK) disable iff (!rstN_i) $rose(memValid_i) |-> own_i)
        else $error("Memory request raised without bus ownership");

    assert property (@(posedge QnCPUCLK) disable iff (!rstN_i) dack_i |=> !dack_i)
        else $error("DACK high on two consecutive cycles");

    assert property (@(posedge QnCPUCLK) disable iff (!rstN_i) regReady_i |=> !regReady_i)
        else $error("Register ready lasted more than one cycle");

endmodule

bind sdmacTop sdmacTop_assertions asrt0 (
    .QnCPUCLK   (QnCPUCLK),
    .rstN_i     (rstN_i),
    .memValid_i (memValid_o),
    .memReady_i (memReady_i),
    .memWrite_i (memWrite_o),
    .memAddr_i  (memAddr_o),
    .memWdata_i (memWdata_o),
    .own_i      (ownO),
    .dack_i     (dackO),
    .regReady_i (regReady_o)
);

// File: bench/sdmacTb.sv
/*
 * SDMAC testbench
 * Memory and SCSI models, xorshift stimulus, register and transfer checks
 */
`timescale 1ns/100ps

module sdmacTb import sdmacPkg::*; ();

    logic        clk;
    logic        rstN = 1'b0;
    logic        regValid = 1'b0;
    logic        regWrite = 1'b0;
    logic [1:0]  regAddr = 2'd0;
    logic [31:0] regWdata = '0;
    logic        regReady;
    logic [31:0] regRdata;
    logic        memValid;
    logic        memReady = 1'b0;
    logic        memWrite;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata = '0;
    logic        brO;
    logic        bgI = 1'b0;
    logic        ownO;
    logic        dreqI = 1'b0;
    logic        dackO;
    logic [7:0]  pdataI = 8'h00;
    logic [7:0]  pdataO;
    logic        intO;

    logic [31:0] rngState = 32'h365f;
    int          errors = 0;
    int          checks = 0;
    bit          hung = 1'b0;
    bit          gapsOn = 1'b0;
    logic        xferDir = 1'b0;     // 1 = memory to SCSI
    logic [31:0] mem [logic [31:0]];
    logic [7:0]  txQ [$];            // Bytes the SCSI chip still offers
    logic [7:0]  rxQ [$];            // Bytes the SCSI chip received
    int          rxWant = 0;
    int          writeCount = 0;
    logic        sBr = 1'b0;         // Sampled at the falling edge
    logic [31:0] sAddr = '0;

    clockGen clk0 (.clk_o(clk));

    sdmacTop #(.FIFO_DEPTH(8)) dut0 (
        .QnCPUCLK   (clk),
        .rstN_i     (rstN),
        .regValid_i (regValid),
        .regWrite_i (regWrite),
        .regAddr_i  (regAddr),
        .regWdata_i (regWdata),
        .regReady_o (regReady),
        .regRdata_o (regRdata),
        .memValid_o (memValid),
        .memReady_i (memReady),
        .memWrite_o (memWrite),
        .memAddr_o  (memAddr),
        .memWdata_o (memWdata),
        .memRdata_i (memRdata),
        .brO        (brO),
        .bgI        (bgI),
        .ownO       (ownO),
        .dreqI      (dreqI),
        .dackO      (dackO),
        .pdataI     (pdataI),
        .pdataO     (pdataO),
        .intO       (intO)
    );

    function automatic logic [31:0] randWord();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // Unwritten locations return a pattern of the full address
    function automatic logic [31:0] memRead(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    task automatic checkWord(input string name, input fifoWordT exp, input fifoWordT act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp.lword, act.lword);
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic raiseTimeout(input string what);
        $display("Timeout: %s", what);
        errors++;
        hung = 1'b1;
    endtask

    task automatic regAccess(input logic wr, input logic [1:0] a, input logic [31:0] wd,
                             output logic [31:0] rd);
        int t;
        rd = '0;
        if (!hung) begin
            @(posedge clk);
            regValid <= 1'b1;
            regWrite <= wr;
            regAddr  <= a;
            regWdata <= wd;
            t = 0;
            @(negedge clk);
            while (!regReady && t < 50) begin
                @(negedge clk);
                t++;
            end
            if (!regReady) begin
                raiseTimeout("register port never answered");
            end else begin
                rd = regRdata;
            end
            @(posedge clk);
            regValid <= 1'b0;
            regWrite <= 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic writeReg(input logic [1:0] a, input logic [31:0] wd);
        logic [31:0] dummy;
        regAccess(1'b1, a, wd, dummy);
    endtask

    task automatic readReg(input logic [1:0] a, output logic [31:0] rd);
        regAccess(1'b0, a, 32'h0, rd);
    endtask

    // Memory and bus grant observation
    always @(negedge clk) begin
        sBr   = brO;
        sAddr = memAddr;
        if (rstN && memValid && memReady) begin
            if (!bgI) begin
                errors++;
                $display("Memory cycle at %h completed while bus grant was low", memAddr);
            end
            if (memWrite) begin
                mem[memAddr] = memWdata;
                writeCount++;
            end
        end
        if (rstN && dackO) begin
            if (xferDir) begin
                rxQ.push_back(pdataO);
            end else if (txQ.size() > 0) begin
                txQ.delete(0);  // Byte taken at the end of DACK
            end
        end
    end

    // All random input gaps come from this one process
    always @(posedge clk) begin
        logic [31:0] r;
        r = randWord();
        memReady <= gapsOn ? (r[1:0] != 2'b00) : 1'b1;
        memRdata <= memRead(sAddr);
        bgI      <= sBr && (bgI || !gapsOn || (r[4:2] == 3'd0));  // Held while requested
        if (xferDir) begin
            dreqI <= (rxQ.size() < rxWant) && (!gapsOn || r[6:5] != 2'b00);
        end else begin
            dreqI <= (txQ.size() > 0) && (!gapsOn || r[6:5] != 2'b00);
        end
        pdataI <= (txQ.size() > 0) ? txQ[0] : 8'h00;
    end

    task automatic runTransfer(input string name, input logic toScsi, input logic [31:0] base,
                               input int nWords, input logic intEn);
        logic [31:0] w;
        logic [31:0] st;
        logic [7:0]  expBytes [$];
        fifoWordT    expW;
        int          t;
        int          k;
        expBytes.delete();
        rxQ.delete();
        txQ.delete();
        writeCount = 0;
        xferDir    = toScsi;
        if (toScsi) begin
            rxWant = 4 * nWords;
            for (k = 0; k < nWords; k++) begin
                w = randWord();
                mem[base + 32'(k * 4)] = w;
                expBytes.push_back(w[31:24]);
                expBytes.push_back(w[23:16]);
                expBytes.push_back(w[15:8]);
                expBytes.push_back(w[7:0]);
            end
        end else begin
            rxWant = 0;
            for (k = 0; k < 4 * nWords; k++) begin
                w = randWord();
                expBytes.push_back(w[7:0]);
                txQ.push_back(w[7:0]);
            end
        end
        writeReg(REG_ADDR, base);
        writeReg(REG_LEN, 32'(nWords));
        st             = '0;
        st[CNTR_DIR]   = toScsi;
        st[CNTR_EN]    = 1'b1;
        st[CNTR_INTEN] = intEn;
        writeReg(REG_CNTR, st);

        st = '0;
        t  = 0;
        while (!st[ISTR_DONE] && t < 2000 && !hung) begin
            readReg(REG_ISTR, st);
            t++;
        end
        if (!st[ISTR_DONE] && !hung) begin
            raiseTimeout({name, " never set the done flag"});
        end
        if (hung) begin
            return;
        end
        readReg(REG_ISTR, st);  // Done stays set until the CPU clears it
        @(negedge clk);
        checkBit({name, " done"}, 1'b1, st[ISTR_DONE]);
        checkBit({name, " fifo empty"}, 1'b1, st[ISTR_FE]);
        checkBit({name, " int pending"}, intEn, st[ISTR_INT]);
        checkBit({name, " intO"}, intEn, intO);
        checkBit({name, " bus request"}, 1'b0, brO);
        checkBit({name, " bus owner"}, 1'b0, ownO);

        if (toScsi) begin
            checkWord({name, " byte count"}, 32'(4 * nWords), 32'(rxQ.size()));
            for (k = 0; k < expBytes.size() && k < rxQ.size(); k++) begin
                checkByte({name, " scsi byte"}, expBytes[k], rxQ[k]);
            end
        end else begin
            checkWord({name, " write count"}, 32'(nWords), 32'(writeCount));
            for (k = 0; k < nWords; k++) begin
                expW.bytes[3] = expBytes[4 * k];      // First byte in the MSB lane
                expW.bytes[2] = expBytes[4 * k + 1];
                expW.bytes[1] = expBytes[4 * k + 2];
                expW.bytes[0] = expBytes[4 * k + 3];
                checkWord({name, " memory word"}, expW, memRead(base + 32'(k * 4)));
            end
        end

        st            = '0;
        st[ISTR_DONE] = 1'b1;
        writeReg(REG_ISTR, st);
        readReg(REG_ISTR, st);
        @(negedge clk);
        checkBit({name, " done cleared"}, 1'b0, st[ISTR_DONE]);
        checkBit({name, " intO cleared"}, 1'b0, intO);
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] rd;
        logic [31:0] exp;
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        // Register readback
        readReg(REG_ISTR, rd);
        checkBit("reset fifo empty", 1'b1, rd[ISTR_FE]);
        checkBit("reset done", 1'b0, rd[ISTR_DONE]);
        v = randWord();
        writeReg(REG_ADDR, v);
        readReg(REG_ADDR, rd);
        checkWord("addr readback", v, rd);
        v = randWord();
        writeReg(REG_LEN, v);
        readReg(REG_LEN, rd);
        checkWord("len readback", {16'h0000, v[15:0]}, rd);
        v          = randWord();
        v[CNTR_EN] = 1'b0;
        writeReg(REG_CNTR, v);
        readReg(REG_CNTR, rd);
        exp             = '0;
        exp[CNTR_DIR]   = v[CNTR_DIR];
        exp[CNTR_INTEN] = v[CNTR_INTEN];
        checkWord("cntr readback", exp, rd);
        writeReg(REG_CNTR, 32'h0);

        runTransfer("scsiToMem", 1'b0, 32'h0000_1000, 8, 1'b1);
        runTransfer("memToScsi", 1'b1, 32'h0000_2000, 8, 1'b0);
        gapsOn = 1'b1;
        runTransfer("scsiToMemGaps", 1'b0, 32'h0001_3000, 12, 1'b0);
        runTransfer("memToScsiGaps", 1'b1, 32'h0002_4000, 12, 1'b1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/sdmacPkg.sv
verilog/sdmacRegs.sv
verilog/sdmacFifo.sv
verilog/scsiPortSm.sv
verilog/busMasterSm.sv
verilog/sdmacTop.sv
bench/clockGen.sv
bench/sdmacTop_assertions.sv
bench/sdmacTb.sv

// File: run.sh
#!/bin/sh
# Build and run the SDMAC testbench with Verilator

verilator --binary --timing --assert --top-module sdmacTb -Mdir obj_dir -o simv -f list.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "Simulation reported failure"
exit 1
